// File: hdl/vdp_pkg.sv
`default_nettype none

package vdp_pkg;

    // ************************************************
    // Data widths
    // ************************************************

    // One CPU data byte, also the width of every VDP control register
    typedef logic [7:0] byte_t;

    // The VRAM is 16 KB, so a full address is 14 bits
    localparam int VRAM_AW = 14;
    localparam int VRAM_DEPTH = 1 << VRAM_AW;

    typedef logic [VRAM_AW-1:0] vram_addr_t;

    // Index into the 16-entry TMS9918 palette
    typedef logic [3:0] color_t;

    // Raster counters, wide enough for 800 columns and 525 lines
    typedef logic [9:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // ************************************************
    // 640x480 at 60 Hz raster timing
    // ************************************************

    // Horizontal: active, front porch, sync pulse, full line
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;

    // Vertical: active, front porch, sync pulse, full frame
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    // ************************************************
    // Control port decode
    // ************************************************

    // Top two bits of the second byte written to port 1
    typedef enum logic [1:0] {
        op_addr_rd = 2'b00,
        op_addr_wr = 2'b01,
        op_reg_wr  = 2'b10,
        op_none    = 2'b11
    } ctl_op_e;

endpackage

`default_nettype wire

// File: hdl/vdp_vram_if.sv
`timescale 1ns/100ps
`default_nettype none

interface vdp_vram_if;
    import vdp_pkg::*;

    // Address load from the control port, with the new address
    logic       addr_load;
    vram_addr_t addr;
    // Set when the address load is in read mode and the buffer must be filled
    logic       prefetch;

    // Data port accesses
    logic       wr_tick;
    logic       rd_tick;
    byte_t      wdata;

    // Read-ahead buffer as seen by the CPU side
    byte_t      rdata;

    modport cpu (
        output addr_load, addr, prefetch, wr_tick, rd_tick, wdata,
        input  rdata
    );

    modport mem (
        input  addr_load, addr, prefetch, wr_tick, rd_tick, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: hdl/vdp_reg_ifce.sv
`timescale 1ns/100ps
`default_nettype none

module vdp_reg_ifce (
    input  wire                 pxclk,
    input  wire                 rst,

    input  wire                 wr0_tick,
    input  wire                 wr1_tick,
    input  wire                 rd0_tick,
    input  wire                 rd1_tick,
    input  wire vdp_pkg::byte_t din,
    input  wire vdp_pkg::byte_t status,

    output vdp_pkg::byte_t      dout,
    output logic                display_en,
    output logic                irq_en,
    output vdp_pkg::color_t     bg_color,

    vdp_vram_if.cpu             vram
);
    import vdp_pkg::*;

    // The eight write-only control registers
    byte_t   regs [0:7];

    // First-byte latch of the two-byte control protocol
    logic    latch_full;
    byte_t   latch_byte;

    // Decode of the byte now on port 1
    ctl_op_e ctl_op;
    logic    second_wr;

    assign ctl_op    = ctl_op_e'(din[7:6]);
    assign second_wr = wr1_tick && latch_full;

    // ************************************************
    // Control port
    // ************************************************

    // The latch flag flips on every port-1 write and is cleared by any other access,
    // so the CPU can always resync by reading status
    always_ff @(posedge pxclk) begin
        if (rst) begin
            latch_full <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr1_tick) begin
            latch_full <= !latch_full;
            if (latch_full && ctl_op == op_reg_wr) begin
                // Register number sits in the low three bits of the second byte
                regs[din[2:0]] <= latch_byte;
            end
        end else if (wr0_tick || rd0_tick || rd1_tick) begin
            latch_full <= 1'b0;
        end
    end

    // Only the first byte of a pair is captured
    always_ff @(posedge pxclk) begin
        if (wr1_tick && !latch_full) begin
            latch_byte <= din;
        end
    end

    // Fields that the rest of the design decodes; the others are held for later modes
    assign display_en = regs[1][6];
    assign irq_en     = regs[1][5];
    assign bg_color   = regs[7][3:0];

    // ************************************************
    // VRAM access
    // ************************************************

    // A second byte with 00 or 01 on top loads the address, high six bits from din
    assign vram.addr_load = second_wr && (ctl_op == op_addr_rd || ctl_op == op_addr_wr);
    assign vram.addr      = {din[5:0], latch_byte};
    assign vram.prefetch  = (ctl_op == op_addr_rd);

    // Port-0 accesses go straight to the VRAM port
    assign vram.wr_tick = wr0_tick;
    assign vram.rd_tick = rd0_tick;
    assign vram.wdata   = din;

    // Read data holds until the next read of either port
    always_ff @(posedge pxclk) begin
        if (rst) begin
            dout <= '0;
        end else if (rd0_tick) begin
            // Old buffer contents; the VRAM port refills it on the same edge
            dout <= vram.rdata;
        end else if (rd1_tick) begin
            dout <= status;
        end
    end

    // The CPU side never issues two accesses in one cycle
    a_one_tick: assert property (@(posedge pxclk) disable iff (rst)
        $onehot0({wr0_tick, wr1_tick, rd0_tick, rd1_tick}));

endmodule

`default_nettype wire

// File: hdl/vdp_vram_port.sv
`timescale 1ns/100ps
`default_nettype none

module vdp_vram_port (
    input  wire     pxclk,
    input  wire     rst,

    vdp_vram_if.mem vram
);
    import vdp_pkg::*;

    // ************************************************
    // Storage
    // ************************************************

    // 16 KB of video memory, one byte per location
    byte_t      mem [0:VRAM_DEPTH-1];

    // Auto-incrementing access pointer, shared by reads and writes
    vram_addr_t addr_q;

    // Location to read into the buffer, and the strobe that does it
    vram_addr_t rd_addr;
    logic       fetch;

    // A read-mode address load or a data read both refill the read-ahead buffer
    assign fetch = (vram.addr_load && vram.prefetch) || vram.rd_tick;

    // On a load the fresh address is used directly, not the stale pointer
    assign rd_addr = vram.addr_load ? vram.addr : addr_q;

    // ************************************************
    // Address counter
    // ************************************************

    // The counter is 14 bits wide, so incrementing past 3FFF wraps to 0
    always_ff @(posedge pxclk) begin
        if (rst) begin
            addr_q <= '0;
        end else if (vram.addr_load) begin
            if (vram.prefetch) begin
                // Buffer takes this location, the pointer moves past it
                addr_q <= vram.addr + 1'b1;
            end else begin
                addr_q <= vram.addr;
            end
        end else if (vram.wr_tick || vram.rd_tick) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // ************************************************
    // Memory ports
    // ************************************************

    // Write at the current pointer
    always_ff @(posedge pxclk) begin
        if (vram.wr_tick) begin
            mem[addr_q] <= vram.wdata;
        end
    end

    // Synchronous read into the read-ahead buffer.
    // On a data read the register block captures the old value on this same edge
    always_ff @(posedge pxclk) begin
        if (fetch) begin
            vram.rdata <= mem[rd_addr];
        end
    end

    // Address loads come from port 1 and writes from port 0, so they cannot overlap
    a_load_vs_write: assert property (@(posedge pxclk) disable iff (rst)
        !(vram.addr_load && vram.wr_tick));

endmodule

`default_nettype wire

// File: hdl/vdp_irq.sv
`timescale 1ns/100ps
`default_nettype none

module vdp_irq (
    input  wire            pxclk,
    input  wire            rst,

    input  wire            frame_tick,
    input  wire            rd_tick,
    input  wire            irq_en,

    output logic           irq,
    output vdp_pkg::byte_t status
);

    // Frame flag, the F bit of the status register
    logic frame_flag;

    // A new frame beats a status read in the same cycle, so no frame is lost
    always_ff @(posedge pxclk) begin
        if (rst) begin
            frame_flag <= 1'b0;
        end else if (frame_tick) begin
            frame_flag <= 1'b1;
        end else if (rd_tick) begin
            frame_flag <= 1'b0;
        end
    end

    // Sprite bits are not modelled and read as zero
    assign status = {frame_flag, 7'b0};

    // Enable only masks the pin; the flag still shows in status
    assign irq = frame_flag && irq_en;

    // An interrupt needs the flag, which itself came from a frame tick or was already held
    a_irq_flag: assert property (@(posedge pxclk) disable iff (rst)
        irq |-> frame_flag && $past(frame_tick || frame_flag));

endmodule

`default_nettype wire

// File: hdl/vdp_raster.sv
`timescale 1ns/100ps
`default_nettype none

module vdp_raster (
    input  wire                  pxclk,
    input  wire                  rst,

    input  wire                  display_en,
    input  wire vdp_pkg::color_t bg_color,

    output vdp_pkg::color_t      color,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 frame_tick
);
    import vdp_pkg::*;

    // Current column and line
    hcount_t hcount_q;
    vcount_t vcount_q;

    logic    line_end;
    logic    frame_end;
    logic    active;
    logic    hsync_win;
    logic    vsync_win;

    // ************************************************
    // Counters
    // ************************************************

    assign line_end  = (hcount_q == hcount_t'(H_TOTAL - 1));
    assign frame_end = (vcount_q == vcount_t'(V_TOTAL - 1));

    // Column runs 0..799, line steps once per column wrap and runs 0..524
    always_ff @(posedge pxclk) begin
        if (rst) begin
            hcount_q <= '0;
            vcount_q <= '0;
        end else if (line_end) begin
            hcount_q <= '0;
            vcount_q <= frame_end ? '0 : vcount_q + 1'b1;
        end else begin
            hcount_q <= hcount_q + 1'b1;
        end
    end

    // ************************************************
    // Decode
    // ************************************************

    assign active = (hcount_q < hcount_t'(H_ACTIVE)) && (vcount_q < vcount_t'(V_ACTIVE));

    // Sync windows start after the front porch
    assign hsync_win = (hcount_q >= hcount_t'(H_ACTIVE + H_FRONT)) &&
                       (hcount_q <  hcount_t'(H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync_win = (vcount_q >= vcount_t'(V_ACTIVE + V_FRONT)) &&
                       (vcount_q <  vcount_t'(V_ACTIVE + V_FRONT + V_SYNC));

    // First pixel time of the first blanked line, start of vertical blanking
    assign frame_tick = (hcount_q == '0) && (vcount_q == vcount_t'(V_ACTIVE));

    // Colour and syncs are all one cycle behind the counters, so they stay aligned
    always_ff @(posedge pxclk) begin
        if (rst) begin
            color <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            color <= (active && display_en) ? bg_color : '0;
            // Both syncs are active low
            hsync <= !hsync_win;
            vsync <= !vsync_win;
        end
    end

    a_hcount_range: assert property (@(posedge pxclk) disable iff (rst)
        hcount_q < hcount_t'(H_TOTAL));

endmodule

`default_nettype wire

// File: hdl/vdp99.sv
`timescale 1ns/100ps
`default_nettype none

module vdp99 (
    // 25 MHz pixel clock
    input  wire                   pxclk,
    input  wire                   rst,

    // CPU side, one-cycle strobes per access
    input  wire                   wr0_tick,
    input  wire                   wr1_tick,
    input  wire                   rd0_tick,
    input  wire                   rd1_tick,
    input  wire vdp_pkg::byte_t   din,
    output wire vdp_pkg::byte_t   dout,
    output wire                   irq,

    // Video side
    output wire vdp_pkg::color_t  color,
    output wire                   hsync,
    output wire                   vsync
);
    import vdp_pkg::*;

    // Register fields used by the raster and interrupt blocks
    wire         display_en;
    wire         irq_en;
    wire color_t bg_color;

    // Start of vertical blanking, and the status byte it feeds
    wire         frame_tick;
    wire byte_t  status;

    // ************************************************
    // CPU register block and VRAM
    // ************************************************

    vdp_vram_if vram_bus ();

    vdp_reg_ifce ifce_i (
        .pxclk      (pxclk),
        .rst        (rst),
        .wr0_tick   (wr0_tick),
        .wr1_tick   (wr1_tick),
        .rd0_tick   (rd0_tick),
        .rd1_tick   (rd1_tick),
        .din        (din),
        .status     (status),
        .dout       (dout),
        .display_en (display_en),
        .irq_en     (irq_en),
        .bg_color   (bg_color),
        .vram       (vram_bus.cpu)
    );

    vdp_vram_port vram_i (
        .pxclk (pxclk),
        .rst   (rst),
        .vram  (vram_bus.mem)
    );

    // ************************************************
    // Interrupt and raster
    // ************************************************

    // A status read is any port-1 read
    vdp_irq irq_i (
        .pxclk      (pxclk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .rd_tick    (rd1_tick),
        .irq_en     (irq_en),
        .irq        (irq),
        .status     (status)
    );

    vdp_raster raster_i (
        .pxclk      (pxclk),
        .rst        (rst),
        .display_en (display_en),
        .bg_color   (bg_color),
        .color      (color),
        .hsync      (hsync),
        .vsync      (vsync),
        .frame_tick (frame_tick)
    );

endmodule

`default_nettype wire

// File: tests/vdp99_tb.sv
`timescale 1ns/100ps
`default_nettype none

module vdp99_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 8;
    localparam int TICK_GAP     = 6;
    localparam int MAX_VECTORS  = 64;

    // 640x480 raster, 800 columns by 525 lines
    localparam int LINE_CYCLES  = 800;
    localparam int FRAME_LINES  = 525;
    localparam int ACTIVE_COLS  = 640;
    localparam int ACTIVE_LINES = 480;
    localparam int HSYNC_FIRST  = 656;
    localparam int HSYNC_LAST   = 751;
    localparam int VSYNC_FIRST  = 490;
    localparam int VSYNC_LAST   = 491;
    localparam int HSYNC_WIDTH  = HSYNC_LAST - HSYNC_FIRST + 1;
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;

    // Vector opcodes, top byte of each word
    localparam logic [7:0] OP_END   = 8'h00;
    localparam logic [7:0] OP_W0    = 8'h01;
    localparam logic [7:0] OP_W1    = 8'h02;
    localparam logic [7:0] OP_R0    = 8'h03;
    localparam logic [7:0] OP_R1    = 8'h04;
    localparam logic [7:0] OP_IRQ   = 8'h05;
    localparam logic [7:0] OP_FRAME = 8'h06;
    localparam logic [7:0] OP_SCAN  = 8'h07;

    logic       pxclk;
    logic       rst;
    logic       wr0_tick;
    logic       wr1_tick;
    logic       rd0_tick;
    logic       rd1_tick;
    logic [7:0] din;
    wire  [7:0] dout;
    wire        irq;
    wire  [3:0] color;
    wire        hsync;
    wire        vsync;

    // Opcode, operand and expected byte per word
    logic [23:0] vectors [0:MAX_VECTORS-1];
    logic        vectors_ready;
    int          frame_cmds;
    int          errors;
    int          checks;

    // Counter position inside the DUT, and the position now shown on the outputs
    int          ctr_h;
    int          ctr_v;
    int          ref_h;
    int          ref_v;
    logic        ref_valid;

    vdp99 dut_i (
        .pxclk    (pxclk),
        .rst      (rst),
        .wr0_tick (wr0_tick),
        .wr1_tick (wr1_tick),
        .rd0_tick (rd0_tick),
        .rd1_tick (rd1_tick),
        .din      (din),
        .dout     (dout),
        .irq      (irq),
        .color    (color),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    initial begin
        pxclk = 1'b0;
        forever #(CLK_PERIOD / 2) pxclk = ~pxclk;
    end

    // ************************************************
    // Reference raster position
    // ************************************************

    // Counters start at 0,0 out of reset and the outputs trail them by one cycle
    always @(posedge pxclk) begin
        if (rst) begin
            ctr_h     <= 0;
            ctr_v     <= 0;
            ref_valid <= 1'b0;
        end else begin
            ref_h     <= ctr_h;
            ref_v     <= ctr_v;
            ref_valid <= 1'b1;
            if (ctr_h == LINE_CYCLES - 1) begin
                ctr_h <= 0;
                ctr_v <= (ctr_v == FRAME_LINES - 1) ? 0 : ctr_v + 1;
            end else begin
                ctr_h <= ctr_h + 1;
            end
        end
    end

    // ************************************************
    // Helpers
    // ************************************************

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        errors++;
        $display("FAIL at %0t: %s is %0h, expected %0h", $time, name, got, expected);
    endtask

    task automatic report_count(input string name, input int got, input int expected);
        errors++;
        $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, expected);
    endtask

    // One CPU strobe, with the read data checked on the cycle after it
    task automatic cpu_access(input logic [7:0] op, input logic [7:0] data,
                              input logic [7:0] exp_byte);
        @(posedge pxclk);
        #DRIVE_DLY;
        din = data;
        case (op)
            OP_W0: wr0_tick = 1'b1;
            OP_W1: wr1_tick = 1'b1;
            OP_R0: rd0_tick = 1'b1;
            default: rd1_tick = 1'b1;
        endcase
        @(posedge pxclk);
        #DRIVE_DLY;
        wr0_tick = 1'b0;
        wr1_tick = 1'b0;
        rd0_tick = 1'b0;
        rd1_tick = 1'b0;
        if (op == OP_R0 || op == OP_R1) begin
            checks++;
            if (dout !== exp_byte) report_value("dout", dout, exp_byte);
        end
        // Keep strobes TICK_GAP cycles apart
        repeat (TICK_GAP - 2) @(posedge pxclk);
    endtask

    // Outputs are registered, so the falling edge sees them settled
    task automatic wait_frame();
        @(negedge pxclk);
        while (vsync !== 1'b1) @(negedge pxclk);
        while (vsync !== 1'b0) @(negedge pxclk);
    endtask

    // Whole lines are compared against the reference position, and the hsync
    // pulses are measured from their edges
    task automatic scan_raster(input int lines, input logic [3:0] active_color);
        logic [3:0] exp_color;
        logic       exp_hsync;
        logic       exp_vsync;
        logic       prev_hsync;
        int         n;
        int         last_fall;
        int         low_start;
        int         periods;
        last_fall = -1;
        low_start = -1;
        periods   = 0;
        @(negedge pxclk);
        while (!(ref_valid && ref_h == 0)) @(negedge pxclk);
        prev_hsync = hsync;
        for (n = 0; n < lines * LINE_CYCLES; n++) begin
            if (n > 0) @(negedge pxclk);
            exp_color = (ref_h < ACTIVE_COLS && ref_v < ACTIVE_LINES) ? active_color : 4'h0;
            exp_hsync = !(ref_h >= HSYNC_FIRST && ref_h <= HSYNC_LAST);
            exp_vsync = !(ref_v >= VSYNC_FIRST && ref_v <= VSYNC_LAST);
            checks++;
            if (color !== exp_color) report_value("color", color, exp_color);
            if (hsync !== exp_hsync) report_value("hsync", hsync, exp_hsync);
            if (vsync !== exp_vsync) report_value("vsync", vsync, exp_vsync);
            if (prev_hsync === 1'b1 && hsync === 1'b0) begin
                if (last_fall >= 0) begin
                    periods++;
                    if (n - last_fall != LINE_CYCLES) begin
                        report_count("hsync period", n - last_fall, LINE_CYCLES);
                    end
                end
                last_fall = n;
                low_start = n;
            end
            if (prev_hsync === 1'b0 && hsync === 1'b1 && low_start >= 0) begin
                if (n - low_start != HSYNC_WIDTH) begin
                    report_count("hsync low width", n - low_start, HSYNC_WIDTH);
                end
            end
            prev_hsync = hsync;
        end
        if (periods == 0) begin
            errors++;
            $display("Scan of %0d lines at %0t saw no complete hsync period", lines, $time);
        end
    endtask

    // ************************************************
    // Vector player
    // ************************************************

    initial begin
        int         idx;
        logic [7:0] op;
        logic [7:0] arg;
        logic [7:0] exp_byte;
        rst           = 1'b1;
        wr0_tick      = 1'b0;
        wr1_tick      = 1'b0;
        rd0_tick      = 1'b0;
        rd1_tick      = 1'b0;
        din           = 8'h00;
        errors        = 0;
        checks        = 0;
        frame_cmds    = 0;
        vectors_ready = 1'b0;
        for (idx = 0; idx < MAX_VECTORS; idx++) begin
            vectors[idx] = '0;
        end
        $readmemh("tests/vdp99_vectors.txt", vectors);
        for (idx = 0; idx < MAX_VECTORS; idx++) begin
            if (vectors[idx][23:16] == OP_FRAME) frame_cmds++;
        end
        vectors_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge pxclk);
        #DRIVE_DLY;
        rst = 1'b0;

        idx = 0;
        while (idx < MAX_VECTORS && vectors[idx][23:16] != OP_END) begin
            op       = vectors[idx][23:16];
            arg      = vectors[idx][15:8];
            exp_byte = vectors[idx][7:0];
            case (op)
                OP_W0, OP_W1, OP_R0, OP_R1: begin
                    cpu_access(op, arg, exp_byte);
                end
                OP_IRQ: begin
                    @(posedge pxclk);
                    #DRIVE_DLY;
                    checks++;
                    if (irq !== exp_byte[0]) report_value("irq", irq, exp_byte[0]);
                end
                OP_FRAME: begin
                    wait_frame();
                end
                OP_SCAN: begin
                    scan_raster(arg, exp_byte[3:0]);
                end
                default: begin
                    errors++;
                    $display("Vector %0d holds unknown opcode %02h", idx, op);
                end
            endcase
            idx++;
        end
        if (idx == 0) begin
            errors++;
            $display("No vectors were read from the vector file");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Each frame wait may take a whole frame, with two frames of slack for the rest
    initial begin
        wait (vectors_ready === 1'b1);
        repeat ((frame_cmds + 2) * FRAME_CYCLES) @(posedge pxclk);
        $display("Watchdog expired after %0d cycles, errors so far: %0d",
                 (frame_cmds + 2) * FRAME_CYCLES, errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/vdp99_vectors.txt
// Each word is opcode, operand, expected byte, two hex digits each
// 01 W0, 02 W1, 03 R0, 04 R1, 05 IRQ, 06 FRAME, 07 SCAN (operand lines, expected colour), 00 end
// VRAM write at 1234, then read back through the read-ahead buffer
023400
025200
011100
012200
013300
014400
023400
021200
030011
030022
030033
030044
// Write across 3FFF and read back over the wrap
02FF00
027F00
015A00
01A500
02FF00
023F00
03005A
0300A5
// One lone control byte, status read, then a fresh pair into register 7
025500
040000
020A00
028700
// Display enabled, then disabled
024000
028100
07040A
020000
028100
070400
// Interrupt enabled
026000
028100
050000
060000
050001
040080
050000
040000
// Interrupt disabled, display enabled
024000
028100
050000
060000
050000
040080
040000
// Scan across vertical blanking into the next frame
07280A
000000

// File: list.f
hdl/vdp_pkg.sv
hdl/vdp_vram_if.sv
hdl/vdp_reg_ifce.sv
hdl/vdp_vram_port.sv
hdl/vdp_irq.sv
hdl/vdp_raster.sv
hdl/vdp99.sv
tests/vdp99_tb.sv
